/* arb_hold.f */
+incdir+include
verilog/arb_hold_pkg.sv
verilog/arb_if.sv
verilog/rr_arbiter.sv
verilog/grant_hold.sv
verilog/arb_cfg_regs.sv
verilog/arb_hold_top.sv
tests/arb_hold_checks.sv
tests/arb_hold_tb.sv

/* Makefile */
TOP = arb_hold_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f arb_hold.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Simulation passed" > /dev/null

clean:
	rm -rf obj_dir

/* tests/arb_hold_tb.sv */
// Seeded stimulus in five phases; the checker module decides pass or fail, the run length is fixed
`include "arb_hold_config.svh"

module arb_hold_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import arb_hold_pkg::*;

  localparam real CLK_PERIOD    = 100.0;
  localparam int  RESET_CYCLES  = 16;
  localparam int  REG_CYCLES    = 40;
  localparam int  FREE_CYCLES   = 200;
  localparam int  HOLD_CYCLES   = 300;
  localparam int  FREEZE_CYCLES = 60;
  localparam int  MASK_CYCLES   = 120;
  localparam int  TOTAL_CYCLES  = RESET_CYCLES + REG_CYCLES + FREE_CYCLES + HOLD_CYCLES +
                                  FREEZE_CYCLES + MASK_CYCLES;
  localparam real WATCHDOG_NS   = 1.5 * TOTAL_CYCLES * CLK_PERIOD;

  logic                    clk;
  logic                    rst_n;
  logic [`ARB_NUM_REQ-1:0] req;
  logic [`ARB_NUM_REQ-1:0] grant_hold;
  logic [`ARB_NUM_REQ-1:0] grant;
  logic                    cfg_wr;
  logic                    cfg_rd;
  logic [`ARB_ADDR_W-1:0]  cfg_addr;
  logic [`ARB_DATA_W-1:0]  cfg_wdata;
  logic [`ARB_DATA_W-1:0]  cfg_rdata;
  logic                    fail_flag;
  integer                  seed;

  arb_hold_top i_arb_hold_top (
    .clk(clk), .rst_n(rst_n), .req(req), .grant_hold(grant_hold), .grant(grant),
    .cfg_wr(cfg_wr), .cfg_rd(cfg_rd), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
  );

  arb_hold_checks i_arb_hold_checks (
    .clk(clk), .rst_n(rst_n), .req(req), .grant_hold(grant_hold), .grant(grant),
    .cfg_wr(cfg_wr), .cfg_rd(cfg_rd), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .fail_flag(fail_flag)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2.0) clk = ~clk;
  end

  // One-cycle write strobe that the register takes at the following edge
  task automatic write_reg(input logic [`ARB_ADDR_W-1:0] addr, input logic [`ARB_DATA_W-1:0] data);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_wr <= 1'b0;
  endtask

  task automatic read_reg(input logic [`ARB_ADDR_W-1:0] addr);
    cfg_rd   <= 1'b1;
    cfg_addr <= addr;
    @(posedge clk);
    cfg_rd <= 1'b0;
  endtask

  // Random request levels with hold inputs low
  task automatic drive_free(input int cycles);
    repeat (cycles) begin
      req        <= `ARB_NUM_REQ'($random(seed));
      grant_hold <= '0;
      @(posedge clk);
    end
  endtask

  // Each hold bit stays high for 1 to 6 beats once it starts
  task automatic drive_holds(input int cycles);
    int                      hold_left [`ARB_NUM_REQ];
    logic [`ARB_NUM_REQ-1:0] hold_bits;
    foreach (hold_left[i]) begin
      hold_left[i] = 0;
    end
    repeat (cycles) begin
      for (int i = 0; i < `ARB_NUM_REQ; i++) begin
        if (hold_left[i] == 0 && ($random(seed) % 4) == 0) begin
          hold_left[i] = int'($unsigned($random(seed)) % 6) + 1;
        end
        hold_bits[i] = (hold_left[i] > 0);
        if (hold_left[i] > 0) begin
          hold_left[i]--;
        end
      end
      req        <= `ARB_NUM_REQ'($random(seed));
      grant_hold <= hold_bits;
      @(posedge clk);
    end
  endtask

  initial begin
    seed = 33;
    rst_n = 1'b0;
    req = '0;
    grant_hold = '0;
    cfg_wr = 1'b0;
    cfg_rd = 1'b0;
    cfg_addr = '0;
    cfg_wdata = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Register access covers the ignored address and the read-only status
    req <= 4'b0110;
    write_reg(REG_MASK, 8'hF5);
    read_reg(REG_MASK);
    write_reg(REG_CTRL, 8'hFE);
    read_reg(REG_CTRL);
    write_reg(REG_CTRL, 8'h01);
    read_reg(REG_CTRL);
    write_reg(REG_STATUS, 8'hFF);
    write_reg(2'd3, 8'hFF);
    read_reg(2'd3);
    read_reg(REG_STATUS);
    write_reg(REG_MASK, 8'h0F);
    read_reg(REG_MASK);
    read_reg(REG_STATUS);

    drive_free(FREE_CYCLES);
    drive_holds(HOLD_CYCLES);

    // Catch whatever is granted in a hold, then freeze updates
    req        <= 4'b1011;
    grant_hold <= '1;
    @(posedge clk);
    write_reg(REG_CTRL, 8'h00);
    repeat (FREEZE_CYCLES / 4) begin
      grant_hold <= `ARB_NUM_REQ'($random(seed));
      @(posedge clk);
    end
    req <= 4'b0101;
    repeat (FREEZE_CYCLES / 4) begin
      grant_hold <= `ARB_NUM_REQ'($random(seed));
      @(posedge clk);
    end
    grant_hold <= '0;
    write_reg(REG_CTRL, 8'h01);

    // Freeze again with nothing held so that the frozen pointer alone keeps the grant steady
    write_reg(REG_CTRL, 8'h00);
    repeat (FREEZE_CYCLES / 2) @(posedge clk);
    write_reg(REG_CTRL, 8'h01);

    // Mask rewritten every ten beats while holds come and go
    for (int c = 0; c < MASK_CYCLES; c++) begin
      cfg_wr     <= (c % 10 == 0);
      cfg_rd     <= (c % 10 == 5);
      cfg_addr   <= (c % 10 == 0) ? REG_MASK : REG_STATUS;
      cfg_wdata  <= `ARB_DATA_W'($random(seed));
      req        <= `ARB_NUM_REQ'($random(seed));
      grant_hold <= (($random(seed) % 3) == 0) ? '1 : '0;
      @(posedge clk);
    end
    cfg_wr     <= 1'b0;
    cfg_rd     <= 1'b0;
    grant_hold <= '0;
    write_reg(REG_MASK, 8'h0F);
    repeat (4) @(posedge clk);

    if (fail_flag) begin
      $display("Simulation failed");
      $fatal(1, "A checker assertion reported a mismatch");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

  // Stop at the first assertion failure
  initial begin
    wait (fail_flag === 1'b1);
    $display("Simulation failed");
    $fatal(1, "A checker assertion reported a mismatch");
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Simulation failed");
    $fatal(1, "The watchdog expired before the test phases finished");
  end

endmodule : arb_hold_tb

/* tests/arb_hold_checks.sv */
// Reference model of the arbitration rules; expects the model to see every edge from reset onward
`include "arb_hold_config.svh"

module arb_hold_checks (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`ARB_NUM_REQ-1:0] req,
  input  logic [`ARB_NUM_REQ-1:0] grant_hold,
  input  logic [`ARB_NUM_REQ-1:0] grant,
  input  logic                    cfg_wr,
  input  logic                    cfg_rd,
  input  logic [`ARB_ADDR_W-1:0]  cfg_addr,
  input  logic [`ARB_DATA_W-1:0]  cfg_wdata,
  input  logic [`ARB_DATA_W-1:0]  cfg_rdata,
  output logic                    fail_flag
);
  timeunit 1ns;
  timeprecision 1ps;

  import arb_hold_pkg::*;

  // Model state mirrors pointer, hold, mask, update enable and read data
  int                     m_ptr;
  req_vec_t               m_hold;
  req_vec_t               m_mask;
  logic                   m_upd;
  logic [`ARB_DATA_W-1:0] m_rdata;

  // Expected raw and final grants for the current cycle
  req_vec_t exp_arb;
  req_vec_t exp_grant;

  // Walk from the pointer upward and stop at the first enabled request
  function automatic req_vec_t pick_round_robin(input req_vec_t reqs, input int start);
    req_vec_t pick;
    int       idx;
    pick = '0;
    idx  = start;
    repeat (`ARB_NUM_REQ) begin
      if (reqs[idx]) begin
        pick[idx] = 1'b1;
        return pick;
      end
      idx = (idx == `ARB_NUM_REQ - 1) ? 0 : idx + 1;
    end
    return pick;
  endfunction

  // Position of the single set bit of a one-hot vector
  function automatic int onehot_index(input req_vec_t vec);
    int pos;
    pos = 0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (vec[i]) begin
        pos = i;
      end
    end
    return pos;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    fail_flag = 1'b1;
  endtask

  initial fail_flag = 1'b0;

  assign exp_arb   = pick_round_robin(req & m_mask, m_ptr);
  assign exp_grant = (m_hold != '0) ? m_hold : exp_arb;

  // Inputs change by non-blocking assignment, so the old values are read here
  always @(posedge clk) begin
    if (!rst_n) begin
      m_ptr   <= 0;
      m_hold  <= '0;
      m_mask  <= '1;
      m_upd   <= 1'b1;
      m_rdata <= '0;
    end else begin
      // Hold loads and the pointer moves only on update-enabled edges
      if (m_upd) begin
        m_hold <= exp_grant & grant_hold;
        if (m_hold == '0 && exp_arb != '0) begin
          m_ptr <= (onehot_index(exp_arb) + 1) % `ARB_NUM_REQ;
        end
      end
      if (cfg_wr && cfg_addr == REG_MASK) begin
        m_mask <= cfg_wdata[`ARB_NUM_REQ-1:0];
      end
      if (cfg_wr && cfg_addr == REG_CTRL) begin
        m_upd <= cfg_wdata[0];
      end
      // Status returns the grant of the read cycle itself
      if (cfg_rd) begin
        case (cfg_addr)
          REG_MASK:   m_rdata <= `ARB_DATA_W'(m_mask);
          REG_CTRL:   m_rdata <= `ARB_DATA_W'(m_upd);
          REG_STATUS: m_rdata <= `ARB_DATA_W'(exp_grant);
          default:    m_rdata <= '0;
        endcase
      end
    end
  end

  grant_model_a: assert property (@(posedge clk) disable iff (!rst_n)
    grant == exp_grant)
    else report_mismatch($sformatf("grant %b, expected %b", $sampled(grant), $sampled(exp_grant)));

  rdata_model_a: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_rdata == m_rdata)
    else report_mismatch($sformatf("cfg_rdata %h, expected %h",
                                   $sampled(cfg_rdata), $sampled(m_rdata)));

  grant_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant))
    else report_mismatch($sformatf("grant %b is not one-hot or zero", $sampled(grant)));

  // A grant taken with its hold bit set stays put in the next cycle
  hold_taken_a: assert property (@(posedge clk) disable iff (!rst_n)
    (m_upd && ((grant & grant_hold) != '0)) |=> (grant == $past(grant)))
    else report_mismatch("held grant changed in the cycle after the hold was taken");

  // Frozen updates with steady requests and mask leave the grant alone
  freeze_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!$past(m_upd) && $stable(req) && $stable(m_mask)) |-> $stable(grant))
    else report_mismatch("grant moved while updates were disabled");

  masked_grant_a: assert property (@(posedge clk) disable iff (!rst_n)
    ((grant & ~m_mask) != '0) |-> (m_hold != '0))
    else report_mismatch($sformatf("grant %b includes a masked requester", $sampled(grant)));

  grant_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
    (grant == '0) |-> (((req & m_mask) == '0) && (m_hold == '0)))
    else report_mismatch("grant is zero although an enabled request or a hold exists");

endmodule : arb_hold_checks

/* verilog/arb_hold_top.sv */
// Top of the arbitration subsystem; final grant is combinational from req, masked requesters never win new grants
`include "arb_hold_config.svh"

module arb_hold_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`ARB_NUM_REQ-1:0] req,
  input  logic [`ARB_NUM_REQ-1:0] grant_hold,
  output logic [`ARB_NUM_REQ-1:0] grant,
  input  logic                   cfg_wr,
  input  logic                   cfg_rd,
  input  logic [`ARB_ADDR_W-1:0]  cfg_addr,
  input  logic [`ARB_DATA_W-1:0]  cfg_wdata,
  output logic [`ARB_DATA_W-1:0]  cfg_rdata
);

  import arb_hold_pkg::*;

  // Enable mask and update control from the register block
  req_vec_t  req_mask;
  logic      update_en;

  // Register address as the enum that the register block decodes
  reg_addr_e cfg_addr_e;

  // Link between the arbiter and the grant holder
  arb_if bus ();

  // Unused address 3 simply falls through to the decoder default
  assign cfg_addr_e = reg_addr_e'(cfg_addr);

  // Disabled requesters are removed before arbitration
  // A grant already held is not affected by the mask
  assign bus.req = req & req_mask;

  arb_cfg_regs i_cfg_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr    (cfg_wr),
    .cfg_rd    (cfg_rd),
    .cfg_addr  (cfg_addr_e),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .grant     (bus.grant),
    .req_mask  (req_mask),
    .update_en (update_en)
  );

  rr_arbiter i_rr_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.arbiter)
  );

  grant_holder i_grant_holder (
    .clk        (clk),
    .rst_n      (rst_n),
    .update_en  (update_en),
    .grant_hold (grant_hold),
    .bus        (bus.holder)
  );

  // Final grant after the hold stage goes straight out
  assign grant = bus.grant;

endmodule : arb_hold_top

/* verilog/arb_cfg_regs.sv */
// Strobe-driven config registers; no bus protocol, writes land next edge and reads return one cycle late
`include "arb_hold_config.svh"

module arb_cfg_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cfg_wr,
  input  logic                    cfg_rd,
  input  arb_hold_pkg::reg_addr_e cfg_addr,
  input  logic [`ARB_DATA_W-1:0]  cfg_wdata,
  output logic [`ARB_DATA_W-1:0]  cfg_rdata,
  input  arb_hold_pkg::req_vec_t  grant,
  output arb_hold_pkg::req_vec_t  req_mask,
  output logic                    update_en
);

  import arb_hold_pkg::*;

  // Read data selected from the current address, before the read register
  logic [`ARB_DATA_W-1:0] rd_data;

  // Mask and control registers
  // Out of reset every requester is enabled and updates are allowed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_mask  <= '1;
      update_en <= 1'b1;
    end else if (cfg_wr) begin
      case (cfg_addr)
        REG_MASK: begin
          req_mask <= cfg_wdata[`ARB_NUM_REQ-1:0];
        end
        REG_CTRL: begin
          update_en <= cfg_wdata[0];
        end
        default: begin
          // REG_STATUS is read-only and address 3 is unused
        end
      endcase
    end
  end

  // Read mux zero-extends each field to the data width
  // Status reflects the final grant in the cycle of the read
  always_comb begin
    rd_data = '0;
    case (cfg_addr)
      REG_MASK: begin
        rd_data[`ARB_NUM_REQ-1:0] = req_mask;
      end
      REG_CTRL: begin
        rd_data[0] = update_en;
      end
      REG_STATUS: begin
        rd_data[`ARB_NUM_REQ-1:0] = grant;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // Read data is captured on the read strobe
  // It holds its value until the next read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_rdata <= '0;
    end else if (cfg_rd) begin
      cfg_rdata <= rd_data;
    end
  end

  // The register port has a single address, so a write and a read in one cycle
  // would leave the caller unsure which access the address belonged to
  no_wr_rd_overlap_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cfg_wr && cfg_rd)
  ) else $error("arb_cfg_regs saw cfg_wr and cfg_rd together");

endmodule : arb_cfg_regs

/* verilog/grant_hold.sv */
// Holds a granted requester for multi-beat transfers; a held grant outlives its request until grant_hold drops
module grant_holder (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  update_en,
  input arb_hold_pkg::req_vec_t grant_hold,
  arb_if.holder                bus
);

  import arb_hold_pkg::*;

  // Currently held grant, zero when nothing is held
  req_vec_t hold;

  // Value to load on the next update-enabled edge
  req_vec_t hold_next;

  // Keep the final grant only for requesters that ask to hold it
  // Since the grant is one-hot, at most one hold bit can be set
  assign hold_next = bus.grant & grant_hold;

  // The hold register only moves when updates are allowed
  // With update_en low the current hold state is frozen as is
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold <= '0;
    end else if (update_en) begin
      hold <= hold_next;
    end
  end

  // A held grant overrides whatever the arbiter picks
  assign bus.grant = (|hold) ? hold : bus.grant_from_arb;

  // Arbiter priority may only move with nothing held and updates enabled
  assign bus.enable_priority_update = !(|hold) && update_en;

  // Once a grant is held it must not change from one cycle to the next
  held_grant_stable_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (|hold) |-> (bus.grant == $past(bus.grant))
  ) else $error("grant_holder held grant changed");

  // The arbiter pointer must stay put while a grant is held
  no_update_while_held_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (|hold) |-> !bus.enable_priority_update
  ) else $error("grant_holder allowed a priority update while holding");

  // An edge with update_en low must leave the hold register unchanged
  hold_frozen_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !update_en |=> $stable(hold)
  ) else $error("grant_holder hold changed with update_en low");

endmodule : grant_holder

/* verilog/rr_arbiter.sv */
// Combinational round-robin grant; pointer only moves when the holder allows it, no request weighting
`include "arb_hold_config.svh"

module rr_arbiter (
  input logic   clk,
  input logic   rst_n,
  arb_if.arbiter bus
);

  import arb_hold_pkg::*;

  // Enough bits to index every requester
  localparam int PTR_W = $clog2(`ARB_NUM_REQ);

  // Requester with the highest priority this cycle
  logic [PTR_W-1:0] ptr;

  // Pointer value that sits just past the granted requester
  logic [PTR_W-1:0] ptr_next;

  // Index of the granted requester, only meaningful when arb_grant is nonzero
  logic [PTR_W-1:0] grant_idx;

  // One-hot raw grant, or zero with no requests
  req_vec_t         arb_grant;

  // Scan the requests starting at the pointer and wrap around
  // The first asserted request wins, so at most one bit is set
  always_comb begin
    int   idx;
    logic found;
    arb_grant = '0;
    grant_idx = '0;
    found     = 1'b0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      idx = (int'(ptr) + i) % `ARB_NUM_REQ;
      if (!found && bus.req[idx]) begin
        arb_grant[idx] = 1'b1;
        grant_idx      = PTR_W'(idx);
        found          = 1'b1;
      end
    end
  end

  // Next priority goes to the requester after the winner
  // The top index wraps back to requester 0
  assign ptr_next = (grant_idx == PTR_W'(`ARB_NUM_REQ - 1)) ? '0 : grant_idx + 1'b1;

  // Pointer only advances on a real grant with updates enabled
  // While the holder keeps a grant, the pointer stays frozen
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (bus.enable_priority_update && (|arb_grant)) begin
      ptr <= ptr_next;
    end
  end

  assign bus.grant_from_arb = arb_grant;

  // The raw grant must never pick more than one requester,
  // and it must only pick requesters that are asking this cycle
  grant_onehot_subset_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(bus.grant_from_arb) && ((bus.grant_from_arb & ~bus.req) == '0)
  ) else $error("rr_arbiter grant is not one-hot or not a subset of req");

endmodule : rr_arbiter

/* verilog/arb_if.sv */
// Internal link between arbiter and grant holder; carries levels only, with no handshake
interface arb_if;

  import arb_hold_pkg::*;

  // Masked request vector, driven by the top level
  req_vec_t req;

  // Raw round-robin grant, valid in the same cycle as req
  req_vec_t grant_from_arb;

  // High when the arbiter may move its priority pointer
  // The grant holder drops it while a grant is held
  logic     enable_priority_update;

  // Final grant after the hold stage
  req_vec_t grant;

  // Arbiter side sees requests and the update permission
  modport arbiter (
    input  req,
    input  enable_priority_update,
    output grant_from_arb
  );

  // Holder side sees the raw grant and owns the final grant
  // It also reads back grant to form its hold value
  modport holder (
    input  grant_from_arb,
    output enable_priority_update,
    output grant
  );

endinterface : arb_if

/* verilog/arb_hold_pkg.sv */
// Shared types only; widths come from the config header, and unlisted register addresses decode to nothing
`include "arb_hold_config.svh"

package arb_hold_pkg;

  // One bit per requester
  // Used for requests, grants, hold inputs and the enable mask
  typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

  // Register map of the configuration block
  // REG_MASK holds the requester enable mask in its low bits
  // REG_CTRL bit 0 allows priority and hold updates
  // REG_STATUS is read-only and returns the current final grant
  // Address 3 is unused, so writes there are dropped and reads return zero
  typedef enum logic [`ARB_ADDR_W-1:0] {
    REG_MASK   = `ARB_ADDR_W'(0),
    REG_CTRL   = `ARB_ADDR_W'(1),
    REG_STATUS = `ARB_ADDR_W'(2)
  } reg_addr_e;

endpackage : arb_hold_pkg

/* include/arb_hold_config.svh */
// Build-time sizing only; requester count is fixed per build and the design assumes ARB_NUM_REQ >= 2
`ifndef ARB_HOLD_CONFIG_SVH
`define ARB_HOLD_CONFIG_SVH

// Number of requesters sharing the resource
// The arbiter pointer width is derived from this value with $clog2
`define ARB_NUM_REQ 4

// Register address width, wide enough for the three defined registers
`define ARB_ADDR_W 2

// Register data width
// Must be at least ARB_NUM_REQ so the mask and status fit in one word
`define ARB_DATA_W 8

`endif
